// ==== rtl/exu_cfg_pkg.sv ====
`default_nettype none

package exu_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Datapath sizes

  localparam int XLEN    = 32;
  localparam int RF_NUM  = 32;
  localparam int RFIDX_W = 5;

  // Dot product works on byte lanes
  localparam int LANE_W  = 8;

  typedef logic [XLEN-1:0]    xlen_t;
  typedef logic [RFIDX_W-1:0] rfidx_t;

endpackage

`default_nettype wire

// ==== rtl/exu_op_pkg.sv ====
`default_nettype none

package exu_op_pkg;

  //////////////////////////////////////////////////////////////////////
  // Pre-decoded operation codes

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_ADDI = 3'd5,
    OP_DOT  = 3'd6,
    OP_LOAD = 3'd7
  } exu_op_t;

  // Immediate forms take the immediate in place of rs2
  function automatic logic op_reads_rs2(exu_op_t op);
    return !(op inside {OP_ADDI, OP_LOAD});
  endfunction

  // Only loads are tracked by the OITF
  function automatic logic op_is_longp(exu_op_t op);
    return op == OP_LOAD;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/exu_regfile.sv ====
`default_nettype none

module exu_regfile
  import exu_cfg_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   i_rst,
  input  wire rfidx_t i_rs1idx,
  input  wire rfidx_t i_rs2idx,
  output xlen_t       o_rs1,
  output xlen_t       o_rs2,
  input  wire logic   i_wen,
  input  wire rfidx_t i_wdidx,
  input  wire xlen_t  i_wdat
);

  xlen_t regs [RF_NUM];

  // x0 is cleared here and never written afterwards
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 0; i < RF_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_wdidx != '0)) begin
      regs[i_wdidx] <= i_wdat;
    end
  end

  // Asynchronous read ports, no bypass
  assign o_rs1 = regs[i_rs1idx];
  assign o_rs2 = regs[i_rs2idx];

endmodule

`default_nettype wire

// ==== rtl/exu_disp.sv ====
`default_nettype none

module exu_disp
  import exu_cfg_pkg::*;
  import exu_op_pkg::*;
#(
  parameter int OITF_DEPTH = 4,
  localparam int ITAG_W = (OITF_DEPTH > 1) ? $clog2(OITF_DEPTH) : 1
) (
  input  wire logic              clk,
  input  wire logic              i_rst,
  input  wire logic              i_valid,
  output logic                   o_ready,
  input  wire exu_op_t           i_op,
  input  wire rfidx_t            i_rs1idx,
  input  wire rfidx_t            i_rs2idx,
  input  wire rfidx_t            i_rdidx,
  input  wire xlen_t             i_imm,
  input  wire xlen_t             i_rs1,
  input  wire xlen_t             i_rs2,
  // OITF status
  input  wire logic              i_dis_ready,
  input  wire logic [ITAG_W-1:0] i_dis_itag,
  input  wire logic              i_match_rs1,
  input  wire logic              i_match_rs2,
  input  wire logic              i_match_rd,
  input  wire logic              i_oitf_empty,
  output logic                   o_oitf_ena,
  output logic                   o_exu_active,
  // To the ALU
  output logic                   o_alu_valid,
  input  wire logic              i_alu_ready,
  output exu_op_t                o_alu_op,
  output xlen_t                  o_alu_op1,
  output xlen_t                  o_alu_op2,
  output rfidx_t                 o_alu_rdidx,
  output logic                   o_alu_rdwen,
  output logic [ITAG_W-1:0]      o_alu_itag
);

  logic is_longp;
  logic rs2en;
  logic rdwen;
  logic dep_stall;
  logic oitf_stall;
  logic wait_q;

  //////////////////////////////////////////////////////////////////////
  // Hazard check

  assign is_longp = op_is_longp(i_op);
  assign rs2en    = op_reads_rs2(i_op);
  assign rdwen    = (i_rdidx != '0);

  // Every operation reads rs1, so its match needs no qualifier
  assign dep_stall  = i_match_rs1 | (rs2en & i_match_rs2) | (rdwen & i_match_rd);
  assign oitf_stall = is_longp & ~i_dis_ready;

  //////////////////////////////////////////////////////////////////////
  // Handshake and routing

  assign o_alu_valid = i_valid & ~dep_stall & ~oitf_stall;
  assign o_ready     = ~dep_stall & ~oitf_stall & i_alu_ready;
  assign o_oitf_ena  = o_alu_valid & i_alu_ready & is_longp;

  assign o_alu_op    = i_op;
  assign o_alu_op1   = i_rs1;
  assign o_alu_op2   = rs2en ? i_rs2 : i_imm;
  assign o_alu_rdidx = i_rdidx;
  assign o_alu_rdwen = rdwen;
  assign o_alu_itag  = i_dis_itag;

  // Instruction held back at dispatch last cycle
  always_ff @(posedge clk) begin
    if (i_rst) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= i_valid & ~o_ready;
    end
  end

  assign o_exu_active = ~i_oitf_empty | i_valid | wait_q;

endmodule

`default_nettype wire

// ==== rtl/exu_alu.sv ====
`default_nettype none

module exu_alu
  import exu_cfg_pkg::*;
  import exu_op_pkg::*;
#(
  parameter int ITAG_W = 2
) (
  input  wire logic              i_valid,
  output logic                   o_ready,
  input  wire exu_op_t           i_op,
  input  wire xlen_t             i_op1,
  input  wire xlen_t             i_op2,
  input  wire rfidx_t            i_rdidx,
  input  wire logic              i_rdwen,
  input  wire logic [ITAG_W-1:0] i_itag,
  // Short write-back path
  output logic                   o_wbck_valid,
  input  wire logic              i_wbck_ready,
  output xlen_t                  o_wbck_wdat,
  output rfidx_t                 o_wbck_rdidx,
  // Load command
  output logic                   o_lsu_cmd_valid,
  input  wire logic              i_lsu_cmd_ready,
  output xlen_t                  o_lsu_cmd_addr,
  output logic [ITAG_W-1:0]      o_lsu_cmd_itag
);

  localparam int LANES = XLEN / LANE_W;

  logic  is_load;
  xlen_t sum;
  xlen_t dot_sum;
  xlen_t result;

  assign is_load = op_is_longp(i_op);

  // One adder for add, add-immediate and load address
  assign sum = i_op1 + i_op2;

  // Unsigned byte-lane dot product, wraps at XLEN
  always_comb begin
    xlen_t lane_a;
    xlen_t lane_b;
    dot_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      lane_a  = xlen_t'(i_op1[i*LANE_W +: LANE_W]);
      lane_b  = xlen_t'(i_op2[i*LANE_W +: LANE_W]);
      dot_sum = dot_sum + lane_a * lane_b;
    end
  end

  always_comb begin
    case (i_op)
      OP_SUB:  result = i_op1 - i_op2;
      OP_AND:  result = i_op1 & i_op2;
      OP_OR:   result = i_op1 | i_op2;
      OP_XOR:  result = i_op1 ^ i_op2;
      OP_DOT:  result = dot_sum;
      default: result = sum;
    endcase
  end

  assign o_wbck_valid = i_valid & ~is_load & i_rdwen;
  assign o_wbck_wdat  = result;
  assign o_wbck_rdidx = i_rdidx;

  assign o_lsu_cmd_valid = i_valid & is_load;
  assign o_lsu_cmd_addr  = sum;
  assign o_lsu_cmd_itag  = i_itag;

  // Ready follows whichever path the operation leaves through
  assign o_ready = is_load ? i_lsu_cmd_ready : (~i_rdwen | i_wbck_ready);

endmodule

`default_nettype wire

// ==== rtl/exu_longp.sv ====
`default_nettype none

module exu_longp
  import exu_cfg_pkg::*;
#(
  parameter int OITF_DEPTH = 4,
  localparam int ITAG_W = (OITF_DEPTH > 1) ? $clog2(OITF_DEPTH) : 1
) (
  input  wire logic              clk,
  input  wire logic              i_rst,
  // Allocation
  input  wire logic              i_dis_ena,
  input  wire rfidx_t            i_dis_rdidx,
  input  wire logic              i_dis_rdwen,
  output logic                   o_dis_ready,
  output logic [ITAG_W-1:0]      o_dis_itag,
  // Scoreboard
  input  wire rfidx_t            i_rs1idx,
  input  wire rfidx_t            i_rs2idx,
  input  wire rfidx_t            i_rdidx,
  input  wire logic              i_rs1en,
  input  wire logic              i_rs2en,
  output logic                   o_match_rs1,
  output logic                   o_match_rs2,
  output logic                   o_match_rd,
  output logic                   o_oitf_empty,
  // Load return
  input  wire logic              i_lsu_valid,
  output logic                   o_lsu_ready,
  input  wire xlen_t             i_lsu_wdat,
  input  wire logic [ITAG_W-1:0] i_lsu_itag,
  // Long write-back path
  output logic                   o_wbck_valid,
  input  wire logic              i_wbck_ready,
  output xlen_t                  o_wbck_wdat,
  output rfidx_t                 o_wbck_rdidx
);

  // Pointers carry a wrap bit above the index
  logic [ITAG_W:0]         alc_ptr;
  logic [ITAG_W:0]         ret_ptr;
  logic [OITF_DEPTH-1:0]   ent_vld;
  rfidx_t                  ent_rdidx [OITF_DEPTH];
  logic                    ent_rdwen [OITF_DEPTH];
  logic                    full;
  logic                    head_rdwen;
  logic                    ret_ena;
  logic                    hit_rs1;
  logic                    hit_rs2;
  logic                    hit_rd;

  function automatic logic [ITAG_W:0] ptr_inc(logic [ITAG_W:0] p);
    if (p[ITAG_W-1:0] == ITAG_W'(OITF_DEPTH - 1)) begin
      return {~p[ITAG_W], {ITAG_W{1'b0}}};
    end
    return {p[ITAG_W], p[ITAG_W-1:0] + 1'b1};
  endfunction

  assign o_oitf_empty = (alc_ptr == ret_ptr);
  assign full         = (alc_ptr[ITAG_W-1:0] == ret_ptr[ITAG_W-1:0])
                      & (alc_ptr[ITAG_W] != ret_ptr[ITAG_W]);
  assign o_dis_ready  = ~full;
  assign o_dis_itag   = alc_ptr[ITAG_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // Retirement, in order from the head

  assign head_rdwen   = ent_rdwen[ret_ptr[ITAG_W-1:0]];
  assign o_lsu_ready  = ~o_oitf_empty & (i_lsu_itag == ret_ptr[ITAG_W-1:0])
                      & (~head_rdwen | i_wbck_ready);
  assign ret_ena      = i_lsu_valid & o_lsu_ready;

  // x0 destinations retire silently
  assign o_wbck_valid = i_lsu_valid & ~o_oitf_empty & head_rdwen
                      & (i_lsu_itag == ret_ptr[ITAG_W-1:0]);
  assign o_wbck_wdat  = i_lsu_wdat;
  assign o_wbck_rdidx = ent_rdidx[ret_ptr[ITAG_W-1:0]];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      alc_ptr <= '0;
      ret_ptr <= '0;
      ent_vld <= '0;
    end else begin
      if (i_dis_ena) begin
        ent_vld[alc_ptr[ITAG_W-1:0]] <= 1'b1;
        alc_ptr <= ptr_inc(alc_ptr);
      end
      if (ret_ena) begin
        ent_vld[ret_ptr[ITAG_W-1:0]] <= 1'b0;
        ret_ptr <= ptr_inc(ret_ptr);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_dis_ena) begin
      ent_rdidx[alc_ptr[ITAG_W-1:0]] <= i_dis_rdidx;
      ent_rdwen[alc_ptr[ITAG_W-1:0]] <= i_dis_rdwen;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scoreboard compare against every live entry

  always_comb begin
    hit_rs1 = 1'b0;
    hit_rs2 = 1'b0;
    hit_rd  = 1'b0;
    for (int i = 0; i < OITF_DEPTH; i++) begin
      if (ent_vld[i] && ent_rdwen[i]) begin
        hit_rs1 = hit_rs1 | (ent_rdidx[i] == i_rs1idx);
        hit_rs2 = hit_rs2 | (ent_rdidx[i] == i_rs2idx);
        hit_rd  = hit_rd  | (ent_rdidx[i] == i_rdidx);
      end
    end
  end

  assign o_match_rs1 = hit_rs1 & i_rs1en;
  assign o_match_rs2 = hit_rs2 & i_rs2en;
  assign o_match_rd  = hit_rd;

endmodule

`default_nettype wire

// ==== rtl/exu_wbck.sv ====
`default_nettype none

module exu_wbck
  import exu_cfg_pkg::*;
(
  // Short path from the ALU
  input  wire logic   i_alu_valid,
  output logic        o_alu_ready,
  input  wire xlen_t  i_alu_wdat,
  input  wire rfidx_t i_alu_rdidx,
  // Long path from the OITF retire side
  input  wire logic   i_lp_valid,
  output logic        o_lp_ready,
  input  wire xlen_t  i_lp_wdat,
  input  wire rfidx_t i_lp_rdidx,
  // Register file write port
  output logic        o_rf_ena,
  output rfidx_t      o_rf_rdidx,
  output xlen_t       o_rf_wdat
);

  logic alu_grant;
  logic lp_grant;

  //////////////////////////////////////////////////////////////////////
  // Fixed priority, long pipe first

  // Nothing outranks the long pipe
  assign o_lp_ready  = 1'b1;
  assign o_alu_ready = ~i_lp_valid;

  assign lp_grant  = i_lp_valid & o_lp_ready;
  assign alu_grant = i_alu_valid & o_alu_ready;

  assign o_rf_ena   = lp_grant | alu_grant;
  assign o_rf_rdidx = lp_grant ? i_lp_rdidx : i_alu_rdidx;
  assign o_rf_wdat  = lp_grant ? i_lp_wdat  : i_alu_wdat;

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
`default_nettype none

module exu_top
  import exu_cfg_pkg::*;
  import exu_op_pkg::*;
#(
  parameter int OITF_DEPTH = 4,
  localparam int ITAG_W = (OITF_DEPTH > 1) ? $clog2(OITF_DEPTH) : 1
) (
  input  wire logic              clk,
  input  wire logic              i_rst,
  // Pre-decoded instruction
  input  wire logic              i_valid,
  output logic                   o_ready,
  input  wire exu_op_t           i_op,
  input  wire rfidx_t            i_rs1idx,
  input  wire rfidx_t            i_rs2idx,
  input  wire rfidx_t            i_rdidx,
  input  wire xlen_t             i_imm,
  // Load command to the load unit
  output logic                   o_lsu_cmd_valid,
  input  wire logic              i_lsu_cmd_ready,
  output xlen_t                  o_lsu_cmd_addr,
  output logic [ITAG_W-1:0]      o_lsu_cmd_itag,
  // Load return
  input  wire logic              i_lsu_valid,
  output logic                   o_lsu_ready,
  input  wire xlen_t             i_lsu_wdat,
  input  wire logic [ITAG_W-1:0] i_lsu_itag,
  // Register file write port and status
  output logic                   o_wbck_ena,
  output rfidx_t                 o_wbck_rdidx,
  output xlen_t                  o_wbck_wdat,
  output logic                   o_oitf_empty,
  output logic                   o_exu_active
);

  xlen_t               rf_rs1;
  xlen_t               rf_rs2;

  logic                alu_valid;
  logic                alu_ready;
  exu_op_t             alu_op;
  xlen_t               alu_op1;
  xlen_t               alu_op2;
  rfidx_t              alu_rdidx;
  logic                alu_rdwen;
  logic [ITAG_W-1:0]   alu_itag;

  logic                oitf_ena;
  logic                dis_ready;
  logic [ITAG_W-1:0]   dis_itag;
  logic                match_rs1;
  logic                match_rs2;
  logic                match_rd;

  logic                alu_wb_valid;
  logic                alu_wb_ready;
  xlen_t               alu_wb_wdat;
  rfidx_t              alu_wb_rdidx;

  logic                lp_wb_valid;
  logic                lp_wb_ready;
  xlen_t               lp_wb_wdat;
  rfidx_t              lp_wb_rdidx;

  exu_regfile u_regfile (
    .clk      (clk),          .i_rst    (i_rst),
    .i_rs1idx (i_rs1idx),     .i_rs2idx (i_rs2idx),
    .o_rs1    (rf_rs1),       .o_rs2    (rf_rs2),
    .i_wen    (o_wbck_ena),   .i_wdidx  (o_wbck_rdidx),  .i_wdat (o_wbck_wdat)
  );

  exu_disp #(.OITF_DEPTH(OITF_DEPTH)) u_disp (
    .clk          (clk),          .i_rst        (i_rst),
    .i_valid      (i_valid),      .o_ready      (o_ready),      .i_op     (i_op),
    .i_rs1idx     (i_rs1idx),     .i_rs2idx     (i_rs2idx),     .i_rdidx  (i_rdidx),
    .i_imm        (i_imm),        .i_rs1        (rf_rs1),       .i_rs2    (rf_rs2),
    .i_dis_ready  (dis_ready),    .i_dis_itag   (dis_itag),
    .i_match_rs1  (match_rs1),    .i_match_rs2  (match_rs2),    .i_match_rd (match_rd),
    .i_oitf_empty (o_oitf_empty), .o_oitf_ena   (oitf_ena),     .o_exu_active (o_exu_active),
    .o_alu_valid  (alu_valid),    .i_alu_ready  (alu_ready),    .o_alu_op   (alu_op),
    .o_alu_op1    (alu_op1),      .o_alu_op2    (alu_op2),
    .o_alu_rdidx  (alu_rdidx),    .o_alu_rdwen  (alu_rdwen),    .o_alu_itag (alu_itag)
  );

  exu_alu #(.ITAG_W(ITAG_W)) u_alu (
    .i_valid         (alu_valid),       .o_ready         (alu_ready),
    .i_op            (alu_op),          .i_op1           (alu_op1),
    .i_op2           (alu_op2),         .i_rdidx         (alu_rdidx),
    .i_rdwen         (alu_rdwen),       .i_itag          (alu_itag),
    .o_wbck_valid    (alu_wb_valid),    .i_wbck_ready    (alu_wb_ready),
    .o_wbck_wdat     (alu_wb_wdat),     .o_wbck_rdidx    (alu_wb_rdidx),
    .o_lsu_cmd_valid (o_lsu_cmd_valid), .i_lsu_cmd_ready (i_lsu_cmd_ready),
    .o_lsu_cmd_addr  (o_lsu_cmd_addr),  .o_lsu_cmd_itag  (o_lsu_cmd_itag)
  );

  // Scoreboard compares are only live while an instruction is offered
  exu_longp #(.OITF_DEPTH(OITF_DEPTH)) u_longp (
    .clk          (clk),          .i_rst        (i_rst),
    .i_dis_ena    (oitf_ena),     .i_dis_rdidx  (alu_rdidx),    .i_dis_rdwen (alu_rdwen),
    .o_dis_ready  (dis_ready),    .o_dis_itag   (dis_itag),
    .i_rs1idx     (i_rs1idx),     .i_rs2idx     (i_rs2idx),     .i_rdidx     (i_rdidx),
    .i_rs1en      (i_valid),      .i_rs2en      (i_valid),
    .o_match_rs1  (match_rs1),    .o_match_rs2  (match_rs2),    .o_match_rd  (match_rd),
    .o_oitf_empty (o_oitf_empty),
    .i_lsu_valid  (i_lsu_valid),  .o_lsu_ready  (o_lsu_ready),
    .i_lsu_wdat   (i_lsu_wdat),   .i_lsu_itag   (i_lsu_itag),
    .o_wbck_valid (lp_wb_valid),  .i_wbck_ready (lp_wb_ready),
    .o_wbck_wdat  (lp_wb_wdat),   .o_wbck_rdidx (lp_wb_rdidx)
  );

  exu_wbck u_wbck (
    .i_alu_valid (alu_wb_valid), .o_alu_ready (alu_wb_ready),
    .i_alu_wdat  (alu_wb_wdat),  .i_alu_rdidx (alu_wb_rdidx),
    .i_lp_valid  (lp_wb_valid),  .o_lp_ready  (lp_wb_ready),
    .i_lp_wdat   (lp_wb_wdat),   .i_lp_rdidx  (lp_wb_rdidx),
    .o_rf_ena    (o_wbck_ena),   .o_rf_rdidx  (o_wbck_rdidx), .o_rf_wdat (o_wbck_wdat)
  );

endmodule

`default_nettype wire

// ==== tb/exu_properties.sv ====
`default_nettype none

module exu_properties
  import exu_cfg_pkg::*;
#(
  parameter int OITF_DEPTH = 4,
  localparam int ITAG_W = (OITF_DEPTH > 1) ? $clog2(OITF_DEPTH) : 1
) (
  input wire logic              clk,
  input wire logic              i_rst,
  input wire logic              o_wbck_ena,
  input wire rfidx_t            o_wbck_rdidx,
  input wire logic              o_lsu_cmd_valid,
  input wire logic              i_lsu_cmd_ready,
  input wire logic              i_lsu_valid,
  input wire logic              o_lsu_ready,
  input wire logic [ITAG_W-1:0] i_lsu_itag,
  input wire logic              o_oitf_empty
);

  logic [ITAG_W:0]   out_cnt;
  logic [ITAG_W-1:0] ret_tag;

  // Loads in flight and the tag due next
  always_ff @(posedge clk) begin
    if (i_rst) begin
      out_cnt <= '0;
      ret_tag <= '0;
    end else begin
      out_cnt <= out_cnt + (ITAG_W+1)'(o_lsu_cmd_valid & i_lsu_cmd_ready)
               - (ITAG_W+1)'(i_lsu_valid & o_lsu_ready);
      if (i_lsu_valid && o_lsu_ready) ret_tag <= ret_tag + 1'b1;
    end
  end

  a_rdidx_nonzero: assert property (@(posedge clk) disable iff (i_rst)
    o_wbck_ena |-> o_wbck_rdidx != '0) else $error("write-back to x0");

  a_no_cmd_full: assert property (@(posedge clk) disable iff (i_rst)
    (!o_oitf_empty && out_cnt == (ITAG_W+1)'(OITF_DEPTH)) |-> !o_lsu_cmd_valid)
    else $error("load command while OITF full");

  a_ret_order: assert property (@(posedge clk) disable iff (i_rst)
    (i_lsu_valid && o_lsu_ready) |-> i_lsu_itag == ret_tag)
    else $error("load return out of order");

  a_empty_after_rst: assert property (@(posedge clk)
    i_rst |=> o_oitf_empty) else $error("OITF not empty after reset");

endmodule

bind exu_top exu_properties #(.OITF_DEPTH(OITF_DEPTH)) u_props (
  .clk             (clk),
  .i_rst           (i_rst),
  .o_wbck_ena      (o_wbck_ena),
  .o_wbck_rdidx    (o_wbck_rdidx),
  .o_lsu_cmd_valid (o_lsu_cmd_valid),
  .i_lsu_cmd_ready (i_lsu_cmd_ready),
  .i_lsu_valid     (i_lsu_valid),
  .o_lsu_ready     (o_lsu_ready),
  .i_lsu_itag      (i_lsu_itag),
  .o_oitf_empty    (o_oitf_empty)
);

`default_nettype wire

// ==== tb/tb_exu.sv ====
`default_nettype none

module tb_clkgen #(
  parameter int HALF = 2
) (
  output logic clk
);

  initial clk = 1'b0;
  always #HALF clk = ~clk;

endmodule

module tb_exu
  import exu_cfg_pkg::*;
  import exu_op_pkg::*;
();

  localparam int OITF_DEPTH = 4;
  localparam int ITAG_W     = 2;
  localparam int N_LINES    = 32;
  localparam int N_FIELDS   = 6;

  logic               clk;
  logic               i_rst;
  logic               i_valid;
  logic               o_ready;
  exu_op_t            i_op;
  rfidx_t             i_rs1idx;
  rfidx_t             i_rs2idx;
  rfidx_t             i_rdidx;
  xlen_t              i_imm;
  logic               o_lsu_cmd_valid;
  logic               i_lsu_cmd_ready;
  xlen_t              o_lsu_cmd_addr;
  logic [ITAG_W-1:0]  o_lsu_cmd_itag;
  logic               i_lsu_valid;
  logic               o_lsu_ready;
  xlen_t              i_lsu_wdat;
  logic [ITAG_W-1:0]  i_lsu_itag;
  logic               o_wbck_ena;
  rfidx_t             o_wbck_rdidx;
  xlen_t              o_wbck_wdat;
  logic               o_oitf_empty;
  logic               o_exu_active;

  xlen_t                     tdata [N_LINES*N_FIELDS];
  xlen_t                     ref_regs [RF_NUM];
  logic [RFIDX_W+XLEN-1:0]   exp_q [$];
  logic [ITAG_W+XLEN-1:0]    ret_q [$];
  logic [15:0]               lfsr;
  logic                      gap_bit;
  logic                      ret_go;
  int                        wr_cnt;
  int                        exp_writes;
  int                        err_cnt;

  tb_clkgen #(.HALF(2)) u_clkgen (.clk(clk));

  exu_top #(.OITF_DEPTH(OITF_DEPTH)) i_exu_top (.*);

  //////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Expected result of each register operation
  function automatic xlen_t ref_result(exu_op_t op, xlen_t a, xlen_t b);
    xlen_t acc;
    acc = '0;
    case (op)
      OP_SUB: return a - b;
      OP_AND: return a & b;
      OP_OR:  return a | b;
      OP_XOR: return a ^ b;
      OP_DOT: begin
        for (int k = 0; k < 4; k++) begin
          acc = acc + xlen_t'(a[8*k +: 8]) * xlen_t'(b[8*k +: 8]);
        end
        return acc;
      end
      default: return a + b;
    endcase
  endfunction

  task automatic stop_on_error();
    err_cnt++;
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_write(rfidx_t rd, xlen_t dat);
    int idx;
    idx = -1;
    for (int k = 0; k < exp_q.size(); k++) begin
      if (idx < 0 && exp_q[k][RFIDX_W+XLEN-1:XLEN] == rd) idx = k;
    end
    assert (idx >= 0) else begin
      $display("Write to x%0d arrived when no write to it was expected", rd);
      stop_on_error();
    end
    assert (exp_q[idx][XLEN-1:0] == dat) else begin
      $display("ERROR test=wbck_x%0d expected=%08h actual=%08h", rd,
               exp_q[idx][XLEN-1:0], dat);
      stop_on_error();
    end
    exp_q.delete(idx);
    wr_cnt++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Random gaps, command ready and return delay

  always @(posedge clk) begin
    logic b0;
    logic b1;
    lfsr = lfsr_step(lfsr);
    b0 = lfsr[0];
    lfsr = lfsr_step(lfsr);
    b1 = lfsr[0];
    gap_bit <= b0 & b1;
    lfsr = lfsr_step(lfsr);
    b0 = lfsr[0];
    lfsr = lfsr_step(lfsr);
    b1 = lfsr[0];
    i_lsu_cmd_ready <= b0 | b1;
    lfsr = lfsr_step(lfsr);
    ret_go <= lfsr[0];
  end

  // Load unit model returns data in command order
  always begin
    logic done;
    @(posedge clk);
    if (!i_rst && ret_q.size() > 0 && ret_go) begin
      i_lsu_valid <= 1'b1;
      i_lsu_wdat  <= ret_q[0][XLEN-1:0];
      i_lsu_itag  <= ret_q[0][ITAG_W+XLEN-1:XLEN];
      done = 1'b0;
      while (!done) begin
        @(negedge clk);
        done = o_lsu_ready;
        if (!done) @(posedge clk);
      end
      void'(ret_q.pop_front());
    end else begin
      i_lsu_valid <= 1'b0;
    end
  end

  // Write-back monitor
  always @(negedge clk) begin
    if (!i_rst && o_wbck_ena) check_write(o_wbck_rdidx, o_wbck_wdat);
  end

  initial begin
    repeat (200 * N_LINES) @(posedge clk);
    $display("Timeout: the instruction stream did not finish in time");
    stop_on_error();
  end

  //////////////////////////////////////////////////////////////////////
  // Test driver with the reference model

  initial begin
    int     base;
    int     load_cnt;
    exu_op_t op;
    xlen_t  val;
    xlen_t  addr;
    logic   fired;
    lfsr = 16'd15946;
    gap_bit = 1'b0;
    ret_go = 1'b0;
    wr_cnt = 0;
    exp_writes = 0;
    err_cnt = 0;
    load_cnt = 0;
    i_rst = 1'b1;
    i_valid = 1'b0;
    i_op = OP_ADD;
    i_rs1idx = '0;
    i_rs2idx = '0;
    i_rdidx = '0;
    i_imm = '0;
    i_lsu_cmd_ready = 1'b0;
    i_lsu_valid = 1'b0;
    i_lsu_wdat = '0;
    i_lsu_itag = '0;
    for (int r = 0; r < RF_NUM; r++) ref_regs[r] = '0;
    $readmemh("tb/exu_testdata.txt", tdata);
    repeat (10) @(posedge clk);
    i_rst <= 1'b0;

    for (int n = 0; n < N_LINES; n++) begin
      base = n * N_FIELDS;
      op   = exu_op_t'(tdata[base][2:0]);
      @(posedge clk);
      while (gap_bit) begin
        i_valid <= 1'b0;
        @(posedge clk);
      end
      i_valid  <= 1'b1;
      i_op     <= op;
      i_rdidx  <= rfidx_t'(tdata[base+1]);
      i_rs1idx <= rfidx_t'(tdata[base+2]);
      i_rs2idx <= rfidx_t'(tdata[base+3]);
      i_imm    <= tdata[base+4];
      // Expected write in program order
      addr = ref_regs[tdata[base+2][4:0]] + tdata[base+4];
      if (op == OP_LOAD) begin
        val = tdata[base+5];
      end else if (op == OP_ADDI) begin
        val = addr;
      end else begin
        val = ref_result(op, ref_regs[tdata[base+2][4:0]], ref_regs[tdata[base+3][4:0]]);
      end
      if (tdata[base+1][4:0] != 5'd0) begin
        ref_regs[tdata[base+1][4:0]] = val;
        exp_q.push_back({tdata[base+1][4:0], val});
        exp_writes++;
      end
      fired = 1'b0;
      while (!fired) begin
        @(negedge clk);
        fired = o_ready;
        if (!fired) @(posedge clk);
      end
      if (op == OP_LOAD) begin
        assert (o_lsu_cmd_valid && i_lsu_cmd_ready) else begin
          $display("Load on line %0d was accepted without a load command", n);
          stop_on_error();
        end
        assert (o_lsu_cmd_addr == addr) else begin
          $display("ERROR test=load_addr_line%0d expected=%08h actual=%08h", n,
                   addr, o_lsu_cmd_addr);
          stop_on_error();
        end
        // OITF slots are handed out in order around the ring
        assert (o_lsu_cmd_itag == ITAG_W'(load_cnt % OITF_DEPTH)) else begin
          $display("ERROR test=load_itag_line%0d expected=%0d actual=%0d", n,
                   load_cnt % OITF_DEPTH, o_lsu_cmd_itag);
          stop_on_error();
        end
        load_cnt++;
        ret_q.push_back({o_lsu_cmd_itag, tdata[base+5]});
      end
    end
    @(posedge clk);
    i_valid <= 1'b0;

    while (ret_q.size() != 0 || !o_oitf_empty) @(negedge clk);
    repeat (3) @(negedge clk);
    assert (exp_q.size() == 0 && wr_cnt == exp_writes) else begin
      $display("ERROR test=write_count expected=%0d actual=%0d", exp_writes, wr_cnt);
      stop_on_error();
    end
    assert (o_oitf_empty && !o_exu_active) else begin
      $display("Execution stage still busy after the last load returned");
      stop_on_error();
    end
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stop_on_error();
    end
  end

endmodule

`default_nettype wire

// ==== tb/exu_testdata.txt ====
// Columns: op rd rs1 rs2 imm load_data (hex)
// op: 0 add 1 sub 2 and 3 or 4 xor 5 addi 6 dot 7 load
5 01 00 00 00001234 00000000
5 02 00 00 fffffff0 00000000
7 03 01 00 00000010 a5a5a5a5
0 04 03 01 00000000 00000000
1 05 02 01 00000000 00000000
6 06 03 04 00000000 00000000
7 07 02 00 00000004 01020304
7 08 02 00 00000008 05060708
7 09 01 00 0000000c 11223344
7 0a 00 00 00000100 deadbeef
7 0b 00 00 00000104 0badf00d
6 0c 07 08 00000000 00000000
2 0d 09 0a 00000000 00000000
3 0e 0b 01 00000000 00000000
4 0f 0e 05 00000000 00000000
7 00 01 00 00000020 ffffffff
0 00 01 02 00000000 00000000
5 03 03 00 00000001 00000000
7 03 03 00 00000000 80000000
0 10 03 03 00000000 00000000
7 11 10 00 00000000 7f7f7f7f
6 12 11 11 00000000 00000000
1 13 00 12 00000000 00000000
5 14 13 00 00000007 00000000
7 04 14 00 00000000 00000055
5 04 04 00 00000001 00000000
3 15 04 06 00000000 00000000
7 16 00 00 00000200 ff00ff00
7 17 00 00 00000204 00ff00ff
6 18 16 17 00000000 00000000
4 19 18 15 00000000 00000000
2 1a 19 0f 00000000 00000000

// ==== verilog.f ====
rtl/exu_cfg_pkg.sv
rtl/exu_op_pkg.sv
rtl/exu_regfile.sv
rtl/exu_disp.sv
rtl/exu_alu.sv
rtl/exu_longp.sv
rtl/exu_wbck.sv
rtl/exu_top.sv
tb/exu_properties.sv
tb/tb_exu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execution stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --assert -f verilog.f --top-module tb_exu -o tb_exu_sim > build.log 2>&1 \
  && ./obj_dir/tb_exu_sim > sim.log 2>&1 \
  || { echo "Build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "Test failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "No result in log"; exit 1; }
exit 0
